/* build.f */
logic/graph_pkg.sv
logic/bus_pkg.sv
logic/edge_cmd_if.sv
logic/vertex_job_if.sv
logic/vertex_edge_reader.sv
logic/read_command_queue.sv
logic/frontier_writer.sv
logic/cu_vertex_bfs.sv
verif/tb_cu_vertex_bfs.sv

/* Bender.yml */
package:
  name: cu_vertex_bfs

sources:
  - logic/graph_pkg.sv
  - logic/bus_pkg.sv
  - logic/edge_cmd_if.sv
  - logic/vertex_job_if.sv
  - logic/vertex_edge_reader.sv
  - logic/read_command_queue.sv
  - logic/frontier_writer.sv
  - logic/cu_vertex_bfs.sv
  - target: test
    files:
      - verif/tb_cu_vertex_bfs.sv

/* verif/tb_cu_vertex_bfs.sv */
`timescale 1ns/1ns

module tb_cu_vertex_bfs;
	import graph_pkg::*;
	import bus_pkg::*;

	localparam int    N_ENTRIES   = 6;
	localparam addr_t EDGE_BASE   = 64'h0000_0002_0000_4000;
	localparam int    WAIT_LIMIT  = 3000;
	localparam int    HOLD_CYCLES = 60;

	logic          clock;
	logic          rstn;
	logic          enabled_in;
	logic [63:0]   cu_configure;
	logic          vertex_valid;
	vertex_job_t   vertex_job;
	logic          vertex_full;
	logic          read_request;
	logic          read_grant;
	logic          read_command_valid;
	read_cmd_t     read_command;
	logic          read_response_valid;
	read_resp_t    read_response;
	logic          parent_write_valid;
	parent_write_t parent_write;
	vertex_id_t    vertex_num_counter;
	edge_idx_t     edge_num_counter;

	// First entry is wide enough to fill the command queue while grants are held
	vertex_job_t job_table [N_ENTRIES] = '{
		'{vertex_id: 32'd7,  edge_index: 32'd100, out_degree: 32'd20},
		'{vertex_id: 32'd3,  edge_index: 32'd40,  out_degree: 32'd0},
		'{vertex_id: 32'd12, edge_index: 32'd200, out_degree: 32'd1},
		'{vertex_id: 32'd21, edge_index: 32'd300, out_degree: 32'd5},
		'{vertex_id: 32'd5,  edge_index: 32'd500, out_degree: 32'd3},
		'{vertex_id: 32'd9,  edge_index: 32'd600, out_degree: 32'd2}
	};

	read_cmd_t     expected_cmds [$];
	parent_write_t expected_writes [$];
	int            resp_due [$];
	vertex_id_t    resp_neighbor [$];
	logic [5:0]    lfsr_state;
	logic          hold_grants;
	logic          accepted_prev = 1'b0;
	logic          response_prev = 1'b0;
	edge_idx_t     writes_seen = '0;
	int            cycle_num = 0;
	int            last_due = 0;
	int            error_count = 0;
	int            check_count = 0;
	int            timeout_count = 0;

	cu_vertex_bfs #(
		.VERTEX_FIFO_DEPTH(32),
		.CMD_FIFO_DEPTH   (16)
	) u_dut (.*);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	//////////////////////////////////////////////////////////////////////
	// Random source and compare tasks
	//////////////////////////////////////////////////////////////////////

	// x^6 + x^5 + 1
	function automatic logic [5:0] lfsr_next(input logic [5:0] state);
		return {state[4:0], state[5] ^ state[4]};
	endfunction

	function automatic logic random_bit();
		random_bit = lfsr_state[5];
		lfsr_state = lfsr_next(lfsr_state);
	endfunction

	task automatic check_strobe(input string name, input logic actual, input logic expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, actual, expected);
		end
	endtask

	task automatic check_command(input read_cmd_t actual, input read_cmd_t expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("CHECK FAILED at %0t: read command %h/%0d, expected %h/%0d", $time,
				actual.address, actual.vertex_id, expected.address, expected.vertex_id);
		end
	endtask

	task automatic check_parent_write(input parent_write_t actual, input parent_write_t expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("CHECK FAILED at %0t: parent write %0d<-%0d, expected %0d<-%0d", $time,
				actual.neighbor, actual.parent, expected.neighbor, expected.parent);
		end
	endtask

	task automatic check_vertex_count(input vertex_id_t actual, input vertex_id_t expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("CHECK FAILED at %0t: vertex count %0d, expected %0d", $time, actual, expected);
		end
	endtask

	task automatic check_edge_count(input edge_idx_t actual, input edge_idx_t expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("CHECK FAILED at %0t: edge count %0d, expected %0d", $time, actual, expected);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Bus side: grants, memory model, output checks
	//////////////////////////////////////////////////////////////////////

	always @(posedge clock) begin
		read_cmd_t want;
		logic      grant_next;
		int        delay;
		int        due;
		cycle_num++;
		if (rstn) begin
			// Strobes follow the accepted grant and the response by one cycle
			check_strobe("read_command_valid", read_command_valid, accepted_prev);
			check_strobe("parent_write_valid", parent_write_valid, response_prev);
			// Table is shorter than the vertex buffer
			check_strobe("vertex_full", vertex_full, 1'b0);
			if (!enabled_in)
				check_strobe("read_request", read_request, 1'b0);
			// Grants are only driven against a raised request
			accepted_prev = read_grant;
			response_prev = read_response_valid;

			if (read_command_valid) begin
				if (expected_cmds.size() == 0) begin
					error_count++;
					$display("Read command at %0t when no command was expected", $time);
				end else begin
					want = expected_cmds.pop_front();
					check_command(read_command, want);
					expected_writes.push_back('{neighbor: vertex_id_t'(want.address + 64'd1000),
						parent: want.vertex_id});
				end
				// Answer in order after 1 to 4 cycles
				delay = 1;
				if (random_bit())
					delay += 2;
				if (random_bit())
					delay += 1;
				due = cycle_num + delay - 1;
				if (due <= last_due)
					due = last_due + 1;
				last_due = due;
				resp_due.push_back(due);
				resp_neighbor.push_back(vertex_id_t'(read_command.address + 64'd1000));
			end

			if (parent_write_valid) begin
				writes_seen++;
				if (expected_writes.size() == 0) begin
					error_count++;
					$display("Parent write at %0t with no edge response behind it", $time);
				end else
					check_parent_write(parent_write, expected_writes.pop_front());
			end
			check_edge_count(edge_num_counter, writes_seen);

			// No grant two cycles in a row, so the request is still up when it lands
			grant_next = random_bit() && !hold_grants && read_request && !read_grant;
			read_grant <= grant_next;

			if (resp_due.size() != 0 && resp_due[0] <= cycle_num) begin
				read_response_valid <= 1'b1;
				read_response       <= '{neighbor: resp_neighbor.pop_front()};
				void'(resp_due.pop_front());
			end else
				read_response_valid <= 1'b0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Reset, vertex table, enable and final checks
	//////////////////////////////////////////////////////////////////////

	initial begin
		int waited;
		int degree_sum;
		rstn                <= 1'b0;
		enabled_in          <= 1'b0;
		cu_configure        <= EDGE_BASE;
		vertex_valid        <= 1'b0;
		vertex_job          <= '0;
		read_grant          <= 1'b0;
		read_response_valid <= 1'b0;
		read_response       <= '0;
		hold_grants         <= 1'b1;
		lfsr_state = 6'd63;
		degree_sum = 0;

		foreach (job_table[i]) begin
			for (int k = 0; k < int'(job_table[i].out_degree); k++)
				expected_cmds.push_back('{address: EDGE_BASE + job_table[i].edge_index + addr_t'(k),
					vertex_id: job_table[i].vertex_id});
			degree_sum += int'(job_table[i].out_degree);
		end

		repeat (8) @(posedge clock);
		rstn <= 1'b1;

		// Jobs go in while the unit is still disabled
		for (int i = 0; i < N_ENTRIES && timeout_count == 0; i++) begin
			waited = 0;
			@(posedge clock);
			while (vertex_full && waited < WAIT_LIMIT) begin
				@(posedge clock);
				waited++;
			end
			if (vertex_full) begin
				timeout_count++;
				$display("Timeout: vertex buffer stayed full, entry %0d not applied", i);
			end else begin
				vertex_valid <= 1'b1;
				vertex_job   <= job_table[i];
				@(posedge clock);
				vertex_valid <= 1'b0;
			end
		end

		if (timeout_count == 0) begin
			repeat (20) @(posedge clock);
			enabled_in <= 1'b1;
			repeat (HOLD_CYCLES) @(posedge clock);
			// Queue must be holding commands by now
			check_strobe("read_request", read_request, 1'b1);
			hold_grants <= 1'b0;

			waited = 0;
			while (vertex_num_counter != vertex_id_t'(N_ENTRIES) && waited < WAIT_LIMIT) begin
				@(posedge clock);
				waited++;
			end
			if (vertex_num_counter != vertex_id_t'(N_ENTRIES)) begin
				timeout_count++;
				$display("Timeout: only %0d of %0d vertices completed", vertex_num_counter,
					N_ENTRIES);
			end
		end

		repeat (10) @(posedge clock);
		check_vertex_count(vertex_num_counter, vertex_id_t'(N_ENTRIES));
		check_edge_count(edge_num_counter, edge_idx_t'(degree_sum));
		if (expected_cmds.size() != 0 || expected_writes.size() != 0) begin
			error_count++;
			$display("%0d read commands and %0d parent writes never arrived",
				expected_cmds.size(), expected_writes.size());
		end

		$display("Checks run: %0d, errors: %0d, timeouts: %0d", check_count, error_count,
			timeout_count);
		if (error_count == 0 && timeout_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* logic/cu_vertex_bfs.sv */
`timescale 1ns/1ns

module cu_vertex_bfs #(
	parameter int VERTEX_FIFO_DEPTH = 32,
	parameter int CMD_FIFO_DEPTH    = 16
) (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   enabled_in,
	input  logic [63:0]            cu_configure,
	input  logic                   vertex_valid,
	input  graph_pkg::vertex_job_t vertex_job,
	output logic                   vertex_full,
	output logic                   read_request,
	input  logic                   read_grant,
	output logic                   read_command_valid,
	output bus_pkg::read_cmd_t     read_command,
	input  logic                   read_response_valid,
	input  bus_pkg::read_resp_t    read_response,
	output logic                   parent_write_valid,
	output bus_pkg::parent_write_t parent_write,
	output graph_pkg::vertex_id_t  vertex_num_counter,
	output graph_pkg::edge_idx_t   edge_num_counter
);
	import bus_pkg::*;

	// Edge array base, taken from the last nonzero configuration word
	addr_t edge_base;
	logic  enabled;

	edge_cmd_if   cmd_bus ();
	vertex_job_if job_bus ();

	//////////////////////////////////////////////////////////////////////
	// Enable and configuration
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if(~rstn) begin
			edge_base <= '0;
			enabled   <= 1'b0;
		end else begin
			if (|cu_configure)
				edge_base <= cu_configure;
			enabled <= enabled_in && (|edge_base);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Vertex intake, edge commands, parent updates
	//////////////////////////////////////////////////////////////////////

	vertex_edge_reader #(
		.VERTEX_FIFO_DEPTH(VERTEX_FIFO_DEPTH)
	) u_reader (
		.clock       (clock       ),
		.rstn        (rstn        ),
		.enabled     (enabled     ),
		.edge_base   (edge_base   ),
		.vertex_valid(vertex_valid),
		.vertex_job  (vertex_job  ),
		.vertex_full (vertex_full ),
		.cmd         (cmd_bus     ),
		.job         (job_bus     )
	);

	read_command_queue #(
		.CMD_FIFO_DEPTH(CMD_FIFO_DEPTH)
	) u_queue (
		.clock             (clock             ),
		.rstn              (rstn              ),
		.enabled           (enabled           ),
		.cmd               (cmd_bus           ),
		.read_request      (read_request      ),
		.read_grant        (read_grant        ),
		.read_command_valid(read_command_valid),
		.read_command      (read_command      )
	);

	frontier_writer u_writer (
		.clock              (clock              ),
		.rstn               (rstn               ),
		.job                (job_bus            ),
		.read_response_valid(read_response_valid),
		.read_response      (read_response      ),
		.parent_write_valid (parent_write_valid ),
		.parent_write       (parent_write       ),
		.vertex_num_counter (vertex_num_counter ),
		.edge_num_counter   (edge_num_counter   )
	);

endmodule

/* logic/frontier_writer.sv */
`timescale 1ns/1ns

module frontier_writer (
	input  logic                   clock,
	input  logic                   rstn,
	vertex_job_if.writer           job,
	input  logic                   read_response_valid,
	input  bus_pkg::read_resp_t    read_response,
	output logic                   parent_write_valid,
	output bus_pkg::parent_write_t parent_write,
	output graph_pkg::vertex_id_t  vertex_num_counter,
	output graph_pkg::edge_idx_t   edge_num_counter
);
	import graph_pkg::*;

	// Edges returned so far for the active vertex
	degree_t response_count;

	//////////////////////////////////////////////////////////////////////
	// Parent update
	//////////////////////////////////////////////////////////////////////

	// Neighbor gets the current vertex as parent
	always_ff @(posedge clock) begin
		if (read_response_valid) begin
			parent_write.neighbor <= read_response.neighbor;
			parent_write.parent   <= job.vertex_id;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Completion and counters
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if(~rstn) begin
			parent_write_valid <= 1'b0;
			job.done           <= 1'b0;
			response_count     <= '0;
			vertex_num_counter <= '0;
			edge_num_counter   <= '0;
		end else begin
			parent_write_valid <= read_response_valid;
			// Zero degree completes on the first active cycle
			job.done <= job.active && ~job.done && (response_count == job.out_degree);

			if (job.done)
				response_count <= '0;
			else if (read_response_valid)
				response_count <= response_count + 1'b1;

			if (read_response_valid)
				edge_num_counter <= edge_num_counter + 1'b1;
			if (job.done)
				vertex_num_counter <= vertex_num_counter + 1'b1;
		end
	end

	// Every response belongs to the vertex the reader holds active
	a_response_while_active : assert property (@(posedge clock) disable iff (~rstn)
		read_response_valid |-> job.active)
		else $error("edge response arrived with no active vertex");

endmodule

/* logic/read_command_queue.sv */
`timescale 1ns/1ns

module read_command_queue #(
	parameter int CMD_FIFO_DEPTH = 16
) (
	input  logic               clock,
	input  logic               rstn,
	input  logic               enabled,
	edge_cmd_if.queue          cmd,
	output logic               read_request,
	input  logic               read_grant,
	output logic               read_command_valid,
	output bus_pkg::read_cmd_t read_command
);
	import bus_pkg::*;

	localparam int PTR_W = $clog2(CMD_FIFO_DEPTH);

	read_cmd_t      cmd_mem [CMD_FIFO_DEPTH];
	logic [PTR_W:0] wr_ptr;
	logic [PTR_W:0] rd_ptr;
	logic [PTR_W:0] used;
	logic [PTR_W:0] used_next;
	logic           full;
	logic           pop;

	assign used = wr_ptr - rd_ptr;
	assign full = (used == (PTR_W+1)'(CMD_FIFO_DEPTH));

	// Grants only count against a raised request
	assign pop = read_grant && read_request;

	// Occupancy after this cycle's push and pop
	assign used_next = used + (PTR_W+1)'(cmd.valid) - (PTR_W+1)'(pop);

	// Two slots of margin for the command already in flight
	assign cmd.almost_full = (used >= (PTR_W+1)'(CMD_FIFO_DEPTH - 2));

	always_ff @(posedge clock) begin
		if (cmd.valid) begin
			cmd_mem[wr_ptr[PTR_W-1:0]].address   <= cmd.address;
			cmd_mem[wr_ptr[PTR_W-1:0]].vertex_id <= cmd.vertex_id;
		end
		if (pop)
			read_command <= cmd_mem[rd_ptr[PTR_W-1:0]];
	end

	always_ff @(posedge clock or negedge rstn) begin
		if(~rstn) begin
			wr_ptr             <= '0;
			rd_ptr             <= '0;
			read_request       <= 1'b0;
			read_command_valid <= 1'b0;
		end else begin
			wr_ptr             <= wr_ptr + (PTR_W+1)'(cmd.valid);
			rd_ptr             <= rd_ptr + (PTR_W+1)'(pop);
			read_request       <= enabled && (used_next != '0);
			read_command_valid <= pop;
		end
	end

	a_no_push_when_full : assert property (@(posedge clock) disable iff (~rstn)
		cmd.valid |-> ~full)
		else $error("read command pushed into a full command queue");

	a_no_grant_without_request : assert property (@(posedge clock) disable iff (~rstn)
		read_grant |-> read_request)
		else $error("read_grant seen while read_request is low");

endmodule

/* logic/vertex_edge_reader.sv */
`timescale 1ns/1ns

module vertex_edge_reader #(
	parameter int VERTEX_FIFO_DEPTH = 32
) (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   enabled,
	input  bus_pkg::addr_t         edge_base,
	input  logic                   vertex_valid,
	input  graph_pkg::vertex_job_t vertex_job,
	output logic                   vertex_full,
	edge_cmd_if.reader             cmd,
	vertex_job_if.reader           job
);
	import graph_pkg::*;
	import bus_pkg::*;

	localparam int PTR_W = $clog2(VERTEX_FIFO_DEPTH);

	localparam logic [1:0] S_IDLE  = 2'd0;
	localparam logic [1:0] S_ISSUE = 2'd1;
	localparam logic [1:0] S_WAIT  = 2'd2;

	vertex_job_t    vertex_mem [VERTEX_FIFO_DEPTH];
	vertex_job_t    head_job;
	logic [PTR_W:0] wr_ptr;
	logic [PTR_W:0] rd_ptr;
	logic           vertex_empty;
	logic           pop;
	logic           issue;
	logic [1:0]     state;
	degree_t        remaining;
	addr_t          next_address;

	//////////////////////////////////////////////////////////////////////
	// Vertex buffer
	//////////////////////////////////////////////////////////////////////

	assign vertex_empty = (wr_ptr == rd_ptr);
	assign vertex_full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
		(wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
	assign head_job     = vertex_mem[rd_ptr[PTR_W-1:0]];

	// Next job taken only when idle and running
	assign pop = (state == S_IDLE) && enabled && ~vertex_empty;

	always_ff @(posedge clock) begin
		if (vertex_valid && ~vertex_full)
			vertex_mem[wr_ptr[PTR_W-1:0]] <= vertex_job;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if(~rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (vertex_valid && ~vertex_full)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Edge command FSM
	//////////////////////////////////////////////////////////////////////

	// One command per cycle unless the queue is close to full
	assign issue = (state == S_ISSUE) && (remaining != '0) && enabled && ~cmd.almost_full;

	always_ff @(posedge clock or negedge rstn) begin
		if(~rstn) begin
			state      <= S_IDLE;
			job.active <= 1'b0;
			cmd.valid  <= 1'b0;
		end else begin
			cmd.valid <= issue;
			case (state)
				S_IDLE : begin
					if (pop) begin
						job.active <= 1'b1;
						state      <= S_ISSUE;
					end
				end
				S_ISSUE : begin
					if (remaining == '0)
						state <= S_WAIT;
				end
				S_WAIT : begin
					// Writer has seen every edge come back
					if (job.done) begin
						job.active <= 1'b0;
						state      <= S_IDLE;
					end
				end
				default : state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (pop) begin
			job.vertex_id  <= head_job.vertex_id;
			job.out_degree <= head_job.out_degree;
			remaining      <= head_job.out_degree;
			next_address   <= edge_base + head_job.edge_index;
		end else if (issue) begin
			cmd.address   <= next_address;
			cmd.vertex_id <= job.vertex_id;
			remaining     <= remaining - 1'b1;
			next_address  <= next_address + 1'b1;
		end
	end

	a_no_push_when_full : assert property (@(posedge clock) disable iff (~rstn)
		vertex_valid |-> ~vertex_full)
		else $error("vertex job pushed into a full vertex buffer");

endmodule

/* logic/vertex_job_if.sv */
`timescale 1ns/1ns

interface vertex_job_if;
	import graph_pkg::*;

	// Held stable while active
	logic       active;
	vertex_id_t vertex_id;
	degree_t    out_degree;

	// Single cycle pulse once every edge of the vertex has returned
	logic       done;

	modport reader (output active, output vertex_id, output out_degree, input done);

	modport writer (input active, input vertex_id, input out_degree, output done);

endinterface

/* logic/edge_cmd_if.sv */
`timescale 1ns/1ns

interface edge_cmd_if;
	import graph_pkg::*;
	import bus_pkg::*;

	logic       valid;
	addr_t      address;
	vertex_id_t vertex_id;

	// Raised with two free slots left in the queue
	logic       almost_full;

	modport reader (output valid, output address, output vertex_id, input almost_full);

	modport queue (input valid, input address, input vertex_id, output almost_full);

endinterface

/* logic/bus_pkg.sv */
package bus_pkg;

	// Word address into the edge array
	parameter int ADDR_W = 64;

	typedef logic [ADDR_W-1:0] addr_t;

	// Edge read command, tagged with the vertex that owns the edge
	typedef struct packed {
		addr_t                 address;
		graph_pkg::vertex_id_t vertex_id;
	} read_cmd_t;

	// One edge word back from memory
	typedef struct packed {
		graph_pkg::vertex_id_t neighbor;
	} read_resp_t;

	// Parent array update
	typedef struct packed {
		graph_pkg::vertex_id_t neighbor;
		graph_pkg::vertex_id_t parent;
	} parent_write_t;

endpackage

/* logic/graph_pkg.sv */
package graph_pkg;

	//////////////////////////////////////////////////////////////////////
	// Graph side widths
	//////////////////////////////////////////////////////////////////////

	// Vertex ids and out-degrees share one width
	parameter int VERTEX_W = 32;

	// Edge array index, also the width of the processed edge counter
	parameter int EDGE_W = 32;

	typedef logic [VERTEX_W-1:0] vertex_id_t;
	typedef logic [EDGE_W-1:0]   edge_idx_t;
	typedef logic [VERTEX_W-1:0] degree_t;

	//////////////////////////////////////////////////////////////////////
	// Vertex job as it enters the vertex buffer
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		vertex_id_t vertex_id;
		edge_idx_t  edge_index;
		degree_t    out_degree;
	} vertex_job_t;

endpackage
